//--- design/eeprom_bus_pkg.sv
`default_nettype none

package eeprom_bus_pkg;

    // fixed upper nibble of every control byte
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    // clocks per quarter bit, a full bit period is four phases
    localparam int CLKS_PER_PHASE = 2;

    localparam int PHASE_CNT_W = (CLKS_PER_PHASE > 1) ? $clog2(CLKS_PER_PHASE) : 1;

    // what the bit engine runs next
    typedef enum logic [1:0]
    {
        SYM_START,   // also used as repeated start
        SYM_STOP,
        SYM_TX_BYTE, // 8 bits out, slave ack in
        SYM_RX_BYTE  // 8 bits in, master ack out
    } sym_kind_t;

endpackage

`default_nettype wire

//--- design/eeprom_cmd_pkg.sv
`default_nettype none

package eeprom_cmd_pkg;

    // 2048 bytes, upper three bits go in the control byte
    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;

    typedef enum logic
    {
        OP_WRITE,
        OP_READ
    } op_t;

endpackage

`default_nettype wire

//--- design/eeprom_cmd_stage.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_cmd_stage
(
    input  logic                               CLK,
    input  logic                               RESET,
    input  logic                               wr,
    input  logic                               rd,
    input  logic [eeprom_cmd_pkg::ADDR_W-1:0] addr,
    input  logic [eeprom_cmd_pkg::DATA_W-1:0] wdata,
    input  logic                               seq_done,
    output logic                               busy,
    output logic                               cmd_valid,
    output eeprom_cmd_pkg::op_t                op,
    output logic [eeprom_cmd_pkg::ADDR_W-1:0] cmd_addr,
    output logic [eeprom_cmd_pkg::DATA_W-1:0] cmd_wdata
);

    logic accept;

    assign accept = !busy && (wr || rd); // strobes while busy are dropped

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy      <= 1'b0;
            cmd_valid <= 1'b0;
            op        <= eeprom_cmd_pkg::OP_WRITE;
        end
        else
        begin
            cmd_valid <= accept;
            if (accept)
            begin
                busy <= 1'b1;
                op   <= wr ? eeprom_cmd_pkg::OP_WRITE : eeprom_cmd_pkg::OP_READ; // write wins
            end
            else if (seq_done)
                busy <= 1'b0;
        end
    end

    // held until the frame ends
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            cmd_addr  <= addr;
            cmd_wdata <= wdata;
        end
    end

endmodule

`default_nettype wire

//--- design/eeprom_frame_seq.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_frame_seq
(
    input  logic                               CLK,
    input  logic                               RESET,
    input  logic                               cmd_valid,
    input  eeprom_cmd_pkg::op_t                op,
    input  logic [eeprom_cmd_pkg::ADDR_W-1:0] cmd_addr,
    input  logic [eeprom_cmd_pkg::DATA_W-1:0] cmd_wdata,
    input  logic                               sym_done,
    input  logic [eeprom_cmd_pkg::DATA_W-1:0] rx_byte,
    input  logic                               slave_ack,
    output logic                               sym_start,
    output eeprom_bus_pkg::sym_kind_t          sym_kind,
    output logic [eeprom_cmd_pkg::DATA_W-1:0] tx_byte,
    output logic                               master_ack,
    output logic                               seq_done,
    output logic [eeprom_cmd_pkg::DATA_W-1:0] seq_rdata,
    output logic                               seq_nack
);

    typedef enum logic [3:0]
    {
        ST_IDLE,
        ST_START,
        ST_CTRL_W,
        ST_ADDR,
        ST_DATA,
        ST_RESTART,
        ST_CTRL_R,
        ST_RX,
        ST_STOP
    } state_t;

    state_t                            state;
    state_t                            nxt;
    logic                              issue;
    logic                              tx_missed;
    eeprom_bus_pkg::sym_kind_t         kind_nxt;
    logic [eeprom_cmd_pkg::DATA_W-1:0] byte_nxt;
    logic [2:0]                        block; // addr bits 10..8

    assign block     = cmd_addr[eeprom_cmd_pkg::ADDR_W-1:8];
    assign tx_missed = sym_done && sym_kind == eeprom_bus_pkg::SYM_TX_BYTE && !slave_ack;
    assign issue     = cmd_valid || (sym_done && state != ST_STOP);

    always_comb
    begin
        nxt = state;
        if (cmd_valid)
            nxt = ST_START;
        else if (sym_done)
        begin
            case (state)
                ST_START:   nxt = ST_CTRL_W;
                ST_CTRL_W:  nxt = tx_missed ? ST_STOP : ST_ADDR;
                ST_ADDR:
                begin
                    if (tx_missed)
                        nxt = ST_STOP;
                    else if (op == eeprom_cmd_pkg::OP_READ)
                        nxt = ST_RESTART; // dummy write done, turn around
                    else
                        nxt = ST_DATA;
                end
                ST_RESTART: nxt = ST_CTRL_R;
                ST_CTRL_R:  nxt = tx_missed ? ST_STOP : ST_RX;
                ST_STOP:    nxt = ST_IDLE;
                default:    nxt = ST_STOP; // data and rx bytes end the frame
            endcase
        end
    end

    always_comb
    begin
        kind_nxt = eeprom_bus_pkg::SYM_TX_BYTE;
        byte_nxt = cmd_wdata;
        case (nxt)
            ST_START, ST_RESTART: kind_nxt = eeprom_bus_pkg::SYM_START;
            ST_CTRL_W:            byte_nxt = {eeprom_bus_pkg::DEVICE_CODE, block, 1'b0};
            ST_ADDR:              byte_nxt = cmd_addr[7:0];
            ST_CTRL_R:            byte_nxt = {eeprom_bus_pkg::DEVICE_CODE, block, 1'b1};
            ST_RX:                kind_nxt = eeprom_bus_pkg::SYM_RX_BYTE;
            ST_STOP:              kind_nxt = eeprom_bus_pkg::SYM_STOP;
            default:              kind_nxt = eeprom_bus_pkg::SYM_TX_BYTE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= ST_IDLE;
            sym_start <= 1'b0;
            seq_done  <= 1'b0;
            seq_nack  <= 1'b0;
            seq_rdata <= '0;
        end
        else
        begin
            state     <= nxt;
            sym_start <= issue;
            seq_done  <= sym_done && state == ST_STOP;
            if (cmd_valid)
                seq_nack <= 1'b0;
            else if (tx_missed)
                seq_nack <= 1'b1;
            if (sym_done && state == ST_RX)
                seq_rdata <= rx_byte;
        end
    end

    // stable for the whole symbol
    always_ff @(posedge CLK)
    begin
        if (issue)
        begin
            sym_kind   <= kind_nxt;
            tx_byte    <= byte_nxt;
            master_ack <= nxt != ST_RX; // single byte read ends with not-ack
        end
    end

endmodule

`default_nettype wire

//--- design/eeprom_bit_engine.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_bit_engine
(
    input  logic                               CLK,
    input  logic                               RESET,
    input  logic                               sym_start,
    input  eeprom_bus_pkg::sym_kind_t          sym_kind,
    input  logic [eeprom_cmd_pkg::DATA_W-1:0] tx_byte,
    input  logic                               master_ack,
    input  logic                               sda_in,
    output logic                               sym_done,
    output logic [eeprom_cmd_pkg::DATA_W-1:0] rx_byte,
    output logic                               slave_ack,
    output logic                               scl,
    output logic                               sda_oe
);

    localparam logic [3:0] ACK_BIT = 4'(eeprom_cmd_pkg::DATA_W);

    logic                                   active;
    logic [eeprom_bus_pkg::PHASE_CNT_W-1:0] clk_cnt;
    logic [1:0]                             phase;
    logic [3:0]                             bit_idx;
    logic [eeprom_cmd_pkg::DATA_W-1:0]      shreg;
    logic                                   is_byte;
    logic                                   is_tx;
    logic                                   phase_end;
    logic                                   last_bit;
    logic                                   sda_drive;

    assign is_byte   = sym_kind == eeprom_bus_pkg::SYM_TX_BYTE ||
                       sym_kind == eeprom_bus_pkg::SYM_RX_BYTE;
    assign is_tx     = sym_kind == eeprom_bus_pkg::SYM_TX_BYTE;
    assign phase_end = clk_cnt == eeprom_bus_pkg::PHASE_CNT_W'(eeprom_bus_pkg::CLKS_PER_PHASE - 1);
    assign last_bit  = !is_byte || bit_idx == ACK_BIT;
    assign sym_done  = active && phase == 2'd3 && phase_end && last_bit;
    assign rx_byte   = shreg;

    // level put on SDA in the middle of phase 0, SCL is low there
    always_comb
    begin
        if (!is_byte)
            sda_drive = sym_kind == eeprom_bus_pkg::SYM_STOP;
        else if (bit_idx != ACK_BIT)
            sda_drive = is_tx && !shreg[eeprom_cmd_pkg::DATA_W-1]; // msb first
        else
            sda_drive = !is_tx && master_ack; // release for the slave ack
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active    <= 1'b0;
            clk_cnt   <= '0;
            phase     <= 2'd0;
            bit_idx   <= 4'd0;
            scl       <= 1'b1; // bus idle
            sda_oe    <= 1'b0;
            slave_ack <= 1'b0;
        end
        else if (sym_start)
        begin
            active  <= 1'b1;
            clk_cnt <= '0;
            phase   <= 2'd0;
            bit_idx <= 4'd0;
            scl     <= 1'b0;
        end
        else if (active)
        begin
            if (!phase_end)
            begin
                clk_cnt <= clk_cnt + 1'b1;
                if (phase == 2'd0 && clk_cnt == '0)
                    sda_oe <= sda_drive;
            end
            else
            begin
                clk_cnt <= '0;
                phase   <= phase + 2'd1;
                case (phase)
                    2'd0:
                    begin
                        if (!is_byte)
                            scl <= 1'b1;
                    end
                    2'd1:
                    begin
                        if (is_byte)
                            scl <= 1'b1;
                        else
                            sda_oe <= sym_kind == eeprom_bus_pkg::SYM_START; // start or stop edge
                    end
                    2'd2:
                    begin
                        if (is_byte && is_tx && bit_idx == ACK_BIT)
                            slave_ack <= !sda_in;
                        else if (sym_kind == eeprom_bus_pkg::SYM_START)
                            scl <= 1'b0;
                    end
                    default:
                    begin
                        if (sym_done)
                            active <= 1'b0; // lines hold until next symbol
                        else
                        begin
                            bit_idx <= bit_idx + 4'd1;
                            scl     <= 1'b0;
                        end
                    end
                endcase
            end
        end
    end

    // shift at the start of phase 3, serves both directions
    always_ff @(posedge CLK)
    begin
        if (sym_start)
            shreg <= tx_byte;
        else if (active && is_byte && phase == 2'd2 && phase_end && bit_idx != ACK_BIT)
            shreg <= {shreg[eeprom_cmd_pkg::DATA_W-2:0], sda_in};
    end

endmodule

`default_nettype wire

//--- design/eeprom_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctrl
(
    input  logic                               CLK,
    input  logic                               RESET,
    input  logic                               wr,
    input  logic                               rd,
    input  logic [eeprom_cmd_pkg::ADDR_W-1:0] addr,
    input  logic [eeprom_cmd_pkg::DATA_W-1:0] wdata,
    output logic                               busy,
    output logic                               done,
    output logic [eeprom_cmd_pkg::DATA_W-1:0] rdata,
    output logic                               nack,
    output logic                               scl,
    output logic                               sda_oe,
    input  logic                               sda_in
);

    logic                              cmd_valid;
    eeprom_cmd_pkg::op_t               op;
    logic [eeprom_cmd_pkg::ADDR_W-1:0] cmd_addr;
    logic [eeprom_cmd_pkg::DATA_W-1:0] cmd_wdata;
    logic                              sym_start;
    eeprom_bus_pkg::sym_kind_t         sym_kind;
    logic [eeprom_cmd_pkg::DATA_W-1:0] tx_byte;
    logic                              master_ack;
    logic                              sym_done;
    logic [eeprom_cmd_pkg::DATA_W-1:0] rx_byte;
    logic                              slave_ack;

    eeprom_cmd_stage u_cmd_stage
    (
        .CLK(CLK), .RESET(RESET),
        .wr(wr), .rd(rd), .addr(addr), .wdata(wdata),
        .seq_done(done),
        .busy(busy), .cmd_valid(cmd_valid), .op(op),
        .cmd_addr(cmd_addr), .cmd_wdata(cmd_wdata)
    );

    eeprom_frame_seq u_frame_seq
    (
        .CLK(CLK), .RESET(RESET),
        .cmd_valid(cmd_valid), .op(op), .cmd_addr(cmd_addr), .cmd_wdata(cmd_wdata),
        .sym_done(sym_done), .rx_byte(rx_byte), .slave_ack(slave_ack),
        .sym_start(sym_start), .sym_kind(sym_kind), .tx_byte(tx_byte),
        .master_ack(master_ack),
        .seq_done(done), .seq_rdata(rdata), .seq_nack(nack)
    );

    eeprom_bit_engine u_bit_engine
    (
        .CLK(CLK), .RESET(RESET),
        .sym_start(sym_start), .sym_kind(sym_kind), .tx_byte(tx_byte),
        .master_ack(master_ack), .sda_in(sda_in),
        .sym_done(sym_done), .rx_byte(rx_byte), .slave_ack(slave_ack),
        .scl(scl), .sda_oe(sda_oe)
    );

endmodule

`default_nettype wire

//--- sim/eeprom_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_slave_model
(
    input  logic CLK,
    input  logic RESET,
    input  logic absent,
    input  logic scl,
    input  logic sda_oe,
    output logic sda_in
);

    logic [7:0]  mem [2048];
    logic        pull;
    logic        sda;
    logic        scl_q;
    logic        sda_q;
    logic        selected;
    logic        reading;
    logic [3:0]  bit_cnt;  // clock pulses seen in the current byte
    logic [1:0]  byte_no;
    logic [7:0]  shift;
    logic [10:0] ptr;

    assign sda    = !(sda_oe || pull); // wired-and of both pull-downs
    assign sda_in = sda;

    // blank fill is low byte xor 5A folded with the block bits
    initial
    begin
        for (int a = 0; a < 2048; a++)
            mem[a] = 8'(a) ^ 8'h5A ^ 8'(a >> 8);
    end

    always @(posedge CLK)
    begin
        scl_q <= scl;
        sda_q <= sda;
        if (RESET || absent)
        begin
            pull     <= 1'b0;
            selected <= 1'b0;
            reading  <= 1'b0;
            bit_cnt  <= 4'd0;
        end
        else if (scl_q && scl && sda_q && !sda) // start or repeated start
        begin
            selected <= 1'b1;
            reading  <= 1'b0;
            bit_cnt  <= 4'd0;
            byte_no  <= 2'd0;
        end
        else if (scl_q && scl && !sda_q && sda)
            selected <= 1'b0; // stop
        else if (selected && !scl_q && scl)
        begin
            bit_cnt <= bit_cnt + 4'd1;
            if (bit_cnt < 4'd8 && !reading)
                shift <= {shift[6:0], sda};
            else if (bit_cnt == 4'd8 && reading && sda)
            begin
                selected <= 1'b0; // not-ack ends the read
                reading  <= 1'b0;
            end
        end
        else if (selected && scl_q && !scl)
        begin
            if (bit_cnt == 4'd8 && !reading)
            begin
                pull <= 1'b1;
                case (byte_no)
                    2'd0:
                    begin
                        ptr[10:8] <= shift[3:1];
                        reading   <= shift[0];
                        if (shift[7:4] != 4'b1010)
                        begin
                            pull     <= 1'b0; // not our device code
                            selected <= 1'b0;
                        end
                    end
                    2'd1:    ptr[7:0] <= shift;
                    default: mem[ptr] <= shift;
                endcase
                if (byte_no != 2'd3)
                    byte_no <= byte_no + 2'd1;
            end
            else if (bit_cnt == 4'd9)
            begin
                bit_cnt <= 4'd0;
                shift   <= mem[ptr];
                pull    <= reading && !mem[ptr][7]; // msb of the read byte
            end
            else if (reading)
                pull <= bit_cnt < 4'd8 && !shift[3'd7 - bit_cnt[2:0]];
        end
    end

endmodule

`default_nettype wire

//--- sim/eeprom_ctrl_checker.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctrl_checker
(
    input logic                      CLK,
    input logic                      RESET,
    input logic                      busy,
    input logic                      done,
    input logic                      scl,
    input logic                      sda_oe,
    input eeprom_bus_pkg::sym_kind_t sym_kind
);

    int   fail_count = 0;
    logic edge_sym;

    assign edge_sym = sym_kind == eeprom_bus_pkg::SYM_START ||
                      sym_kind == eeprom_bus_pkg::SYM_STOP;

    done_pulse: assert property (@(posedge CLK) disable iff (RESET) done |=> !done)
        else begin $error("done longer than one cycle"); fail_count = fail_count + 1; end

    busy_after_done: assert property (@(posedge CLK) disable iff (RESET) done |=> !busy)
        else begin $error("busy still high after done"); fail_count = fail_count + 1; end

    idle_bus: assert property (@(posedge CLK) disable iff (RESET) !busy |-> scl && !sda_oe)
        else begin $error("bus not idle while not busy"); fail_count = fail_count + 1; end

    sda_stable_high: assert property (@(posedge CLK) disable iff (RESET)
        scl && $past(scl) && $changed(sda_oe) |-> busy && edge_sym)
        else begin $error("sda moved while scl high"); fail_count = fail_count + 1; end

endmodule

`default_nettype wire

//--- sim/tb_eeprom_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_ctrl;

    localparam int NUM_ENTRIES = 14;
    localparam int MEM_BYTES   = 1 << eeprom_cmd_pkg::ADDR_W;
    // a full read frame per entry plus reset and slack
    localparam int WATCHDOG_NS = NUM_ENTRIES * 39 * 8 * 20 + 20000;

    localparam logic [1:0] K_WR      = 2'd0;
    localparam logic [1:0] K_RD      = 2'd1;
    localparam logic [1:0] K_WR_BUSY = 2'd2; // second wr while busy
    localparam logic [1:0] K_WR_RD   = 2'd3; // wr and rd together

    typedef struct packed
    {
        logic [1:0]                        kind;
        logic [eeprom_cmd_pkg::ADDR_W-1:0] addr;
        logic                              absent;
        logic                              nack;
    } entry_t;

    logic                              CLK;
    logic                              RESET;
    logic                              wr;
    logic                              rd;
    logic [eeprom_cmd_pkg::ADDR_W-1:0] addr;
    logic [eeprom_cmd_pkg::DATA_W-1:0] wdata;
    logic                              busy;
    logic                              done;
    logic [eeprom_cmd_pkg::DATA_W-1:0] rdata;
    logic                              nack;
    logic                              scl;
    logic                              sda_oe;
    logic                              sda_in;
    logic                              absent;

    entry_t                            table_q [NUM_ENTRIES];
    logic [eeprom_cmd_pkg::DATA_W-1:0] shadow [MEM_BYTES];
    entry_t                            ent;
    logic [31:0]                       rnd;
    logic [eeprom_cmd_pkg::DATA_W-1:0] data;
    int                                seed;
    int                                idx;

    eeprom_ctrl u_eeprom_ctrl
    (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr), .wdata(wdata),
        .busy(busy), .done(done), .rdata(rdata), .nack(nack),
        .scl(scl), .sda_oe(sda_oe), .sda_in(sda_in)
    );

    eeprom_slave_model u_slave
    (
        .CLK(CLK), .RESET(RESET), .absent(absent),
        .scl(scl), .sda_oe(sda_oe), .sda_in(sda_in)
    );

    bind eeprom_ctrl eeprom_ctrl_checker u_checker
    (
        .CLK(CLK), .RESET(RESET), .busy(busy), .done(done),
        .scl(scl), .sda_oe(sda_oe), .sym_kind(sym_kind)
    );

    function automatic logic [7:0] blank_byte(input int a);
        return 8'(a) ^ 8'h5A ^ 8'(a >> 8);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("Done: errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    initial
    begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: a transaction never completed");
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        RESET  = 1'b1;
        wr     = 1'b0;
        rd     = 1'b0;
        addr   = '0;
        wdata  = '0;
        absent = 1'b0;
        seed   = 77162;
        for (idx = 0; idx < MEM_BYTES; idx++)
            shadow[idx] = blank_byte(idx);

        table_q[0]  = '{K_WR,      11'h123, 1'b0, 1'b0};
        table_q[1]  = '{K_RD,      11'h123, 1'b0, 1'b0};
        table_q[2]  = '{K_RD,      11'h045, 1'b0, 1'b0}; // never written
        table_q[3]  = '{K_WR,      11'h2A7, 1'b0, 1'b0};
        table_q[4]  = '{K_WR,      11'h5A7, 1'b0, 1'b0}; // same low byte in another block
        table_q[5]  = '{K_RD,      11'h2A7, 1'b0, 1'b0};
        table_q[6]  = '{K_RD,      11'h5A7, 1'b0, 1'b0};
        table_q[7]  = '{K_WR,      11'h123, 1'b1, 1'b1};
        table_q[8]  = '{K_RD,      11'h123, 1'b1, 1'b1};
        table_q[9]  = '{K_RD,      11'h123, 1'b0, 1'b0};
        table_q[10] = '{K_WR_BUSY, 11'h300, 1'b0, 1'b0};
        table_q[11] = '{K_RD,      11'h300, 1'b0, 1'b0};
        table_q[12] = '{K_WR_RD,   11'h7FF, 1'b0, 1'b0};
        table_q[13] = '{K_RD,      11'h7FF, 1'b0, 1'b0};

        repeat (3) @(posedge CLK);
        #2 RESET = 1'b0;

        for (idx = 0; idx < NUM_ENTRIES; idx++)
        begin
            ent  = table_q[idx];
            rnd  = $random(seed);
            data = rnd[7:0];
            @(posedge CLK);
            #2;
            absent = ent.absent;
            addr   = ent.addr;
            wdata  = data;
            wr     = ent.kind != K_RD;
            rd     = ent.kind == K_RD || ent.kind == K_WR_RD;
            @(posedge CLK);
            #2;
            wr = 1'b0;
            rd = 1'b0;
            check_value("busy", 32'(busy), 32'd1);
            if (ent.kind == K_WR_BUSY)
            begin
                wr    = 1'b1; // must be dropped
                wdata = data ^ 8'hA5;
                @(posedge CLK);
                #2;
                wr = 1'b0;
            end
            while (done !== 1'b1)
            begin
                @(posedge CLK);
                #2;
            end
            check_value("nack", 32'(nack), 32'(ent.nack));
            if (ent.kind == K_RD && !ent.nack)
                check_value("rdata", 32'(rdata), 32'(shadow[ent.addr]));
            if (ent.kind != K_RD && !ent.nack)
                shadow[ent.addr] = data;
            @(posedge CLK);
            #2;
            check_value("busy", 32'(busy), 32'd0);
            check_value("scl", 32'(scl), 32'd1);
            check_value("sda_oe", 32'(sda_oe), 32'd0);
        end

        if (u_eeprom_ctrl.u_checker.fail_count == 0)
        begin
            $display("Done: no errors");
            $finish;
        end
        else
        begin
            $display("Done: errors found");
            $fatal(1, "bus checker assertions failed");
        end
    end

endmodule

`default_nettype wire

//--- eeprom_ctrl.f
design/eeprom_bus_pkg.sv
design/eeprom_cmd_pkg.sv
design/eeprom_cmd_stage.sv
design/eeprom_frame_seq.sv
design/eeprom_bit_engine.sv
design/eeprom_ctrl.sv
sim/eeprom_slave_model.sv
sim/eeprom_ctrl_checker.sv
sim/tb_eeprom_ctrl.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_eeprom_ctrl
FLAGS     ?= --binary --timing --assert
OBJ_DIR   ?= obj_dir
FILELIST  ?= eeprom_ctrl.f

SIM_FILES = sim/eeprom_slave_model.sv sim/eeprom_ctrl_checker.sv sim/tb_eeprom_ctrl.sv

.PHONY: all compile run clean

all: run

compile: $(FILELIST) $(SIM_FILES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulation is the result
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
